// File: dcache.f
verilog/dcache_bus_pkg.sv
verilog/dcache_geom_pkg.sv
verilog/dcache_array_if.sv
verilog/sdp_ram.sv
verilog/dcache_way_store.sv
verilog/dcache_set_state.sv
verilog/dcache_victim_buf.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: test/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam time CLK_PERIOD     = 40ns;
    localparam int  RESET_CYCLES   = 10;
    localparam int  NUM_REQ        = 400;
    // memory wait plus the cycles around it
    localparam int  LONGEST_REFILL = 11;
    localparam int  LONGEST_WB     = 8;
    localparam time TIMEOUT =
        (NUM_REQ * (LONGEST_REFILL + LONGEST_WB + 4) + RESET_CYCLES + 20) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cpu_rreq;
    logic                  cpu_wreq;
    dcache_bus_pkg::addr_t cpu_addr;
    dcache_bus_pkg::word_t cpu_wdata;
    dcache_bus_pkg::strb_t cpu_wsel;
    logic                  cpu_rdata_valid;
    dcache_bus_pkg::word_t cpu_rdata;
    logic                  stall;
    logic                  mem_rvalid;
    dcache_bus_pkg::line_t mem_rdata;
    logic                  mem_ren;
    dcache_bus_pkg::addr_t mem_araddr;
    logic                  mem_bvalid;
    logic                  mem_wen;
    dcache_bus_pkg::addr_t mem_awaddr;
    dcache_bus_pkg::line_t mem_wdata;

    // reference word store, index is {tag sel, set sel, word}
    dcache_bus_pkg::word_t ref_mem [128];
    logic [15:0]           line_written;
    logic [31:0]           rng;
    logic                  wen_last;

    // request now in stage 2
    logic                  p_rd;
    logic                  p_wr;
    logic                  p_first;
    logic [6:0]            p_idx;
    dcache_bus_pkg::word_t p_wdata;
    dcache_bus_pkg::strb_t p_wsel;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top #(
        .INDEX_W (7)
    ) UUT (
        .clk               (clk),
        .rst               (rst),
        .cpu_rreq_i        (cpu_rreq),
        .cpu_wreq_i        (cpu_wreq),
        .cpu_addr_i        (cpu_addr),
        .cpu_wdata_i       (cpu_wdata),
        .cpu_wsel_i        (cpu_wsel),
        .cpu_rdata_valid_o (cpu_rdata_valid),
        .cpu_rdata_o       (cpu_rdata),
        .stall_o           (stall),
        .mem_rvalid_i      (mem_rvalid),
        .mem_rdata_i       (mem_rdata),
        .mem_ren_o         (mem_ren),
        .mem_araddr_o      (mem_araddr),
        .mem_bvalid_i      (mem_bvalid),
        .mem_wen_o         (mem_wen),
        .mem_awaddr_o      (mem_awaddr),
        .mem_wdata_o       (mem_wdata)
    );

    dcache_mem_model #(
        .SEED (32'hca42)
    ) u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_ren_i    (mem_ren),
        .mem_araddr_i (mem_araddr),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .mem_wen_i    (mem_wen),
        .mem_awaddr_i (mem_awaddr),
        .mem_wdata_i  (mem_wdata),
        .mem_bvalid_o (mem_bvalid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // tag sel in addr[31:30], set sel in the low index bits
    function automatic dcache_bus_pkg::addr_t word_addr(input logic [6:0] idx);
        return {idx[6:5], 18'b0, 5'b0, idx[4:3], idx[2:0], 2'b00};
    endfunction

    function automatic dcache_bus_pkg::word_t merge_bytes(input dcache_bus_pkg::word_t old_w,
                                                          input dcache_bus_pkg::word_t new_w,
                                                          input dcache_bus_pkg::strb_t sel);
        dcache_bus_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_writeback();
        logic [3:0]            slot;
        dcache_bus_pkg::line_t expected;
        slot = {mem_awaddr[31:30], mem_awaddr[6:5]};
        for (int w = 0; w < 8; w++) begin
            expected[32*w +: 32] = ref_mem[{slot, w[2:0]}];
        end
        check_value("write-back address", word_addr({slot, 3'b000}), mem_awaddr);
        check_value("write-back of a written line", 1, line_written[slot]);
        check_value("write-back line", expected, mem_wdata);
    endtask

    // one mid-cycle look at the DUT outputs
    task automatic sample_cycle(input int waited);
        if (mem_wen && !wen_last) begin
            check_writeback();
        end
        wen_last = mem_wen;
        if (mem_ren) begin
            check_value("read during write-back", 0, mem_wen);
            check_value("refill address", word_addr({p_idx[6:3], 3'b000}), mem_araddr);
        end
        if (p_first && waited == 0) begin
            check_value("first read stalls", 1, stall);
            check_value("first read raises mem_ren", 1, mem_ren);
        end
        if (!stall) begin
            if (waited > 0) begin
                check_value("miss ends on refill", 1, mem_rvalid);
            end
            if (p_rd) begin
                check_value("read data valid", 1, cpu_rdata_valid);
                check_value("read data word", ref_mem[p_idx], cpu_rdata);
            end else begin
                check_value("no read data", 0, cpu_rdata_valid);
            end
        end
    endtask

    // present a request, hold it through any stall
    task automatic issue(input logic rd, input logic wr, input logic [6:0] idx,
                         input dcache_bus_pkg::word_t wdata, input dcache_bus_pkg::strb_t wsel);
        int waited;
        #2;
        cpu_rreq  = rd;
        cpu_wreq  = wr;
        cpu_addr  = word_addr(idx);
        cpu_wdata = wdata;
        cpu_wsel  = wsel;
        waited    = 0;
        do begin
            @(negedge clk);
            sample_cycle(waited);
            waited++;
        end while (stall);
        // stage 2 retires at the coming edge
        if (p_wr) begin
            ref_mem[p_idx]           = merge_bytes(ref_mem[p_idx], p_wdata, p_wsel);
            line_written[p_idx[6:3]] = 1'b1;
        end
        p_rd    = rd;
        p_wr    = wr;
        p_idx   = idx;
        p_wdata = wdata;
        p_wsel  = wsel;
        p_first = 1'b0;
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [6:0]            idx;
        logic [6:0]            last_idx;
        logic [31:0]           pick;
        dcache_bus_pkg::word_t wdata;
        dcache_bus_pkg::strb_t wsel;
        rng          = 32'hca42;
        wen_last     = 1'b0;
        line_written = '0;
        p_rd         = 1'b0;
        p_wr         = 1'b0;
        p_first      = 1'b0;
        p_idx        = '0;
        p_wdata      = '0;
        p_wsel       = '0;
        rst          = 1'b1;
        cpu_rreq     = 1'b0;
        cpu_wreq     = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_wsel     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset stall_o", 0, stall);
        check_value("reset mem_ren_o", 0, mem_ren);
        check_value("reset mem_wen_o", 0, mem_wen);
        check_value("reset cpu_rdata_valid_o", 0, cpu_rdata_valid);
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = u_mem.store[i / 8][32*(i % 8) +: 32];
        end
        @(posedge clk);
        // the first access is a read of a cold cache
        rng      = lcg_step(rng);
        last_idx = rng[22:16];
        issue(1'b1, 1'b0, last_idx, '0, '0);
        p_first = 1'b1;
        for (int n = 1; n < NUM_REQ; n++) begin
            rng   = lcg_step(rng);
            pick  = rng;
            rng   = lcg_step(rng);
            wdata = rng;
            rng   = lcg_step(rng);
            wsel  = rng[31:28];
            // one in four goes back to the last word
            idx = (pick[31:30] == 2'b00) ? last_idx : pick[22:16];
            issue(pick[27:24] < 4'd6, pick[27:24] >= 4'd6 && pick[27:24] < 4'd13,
                  idx, wdata, wsel);
            last_idx = idx;
        end
        // retire the last request, then let the victim buffer drain
        issue(1'b0, 1'b0, '0, '0, '0);
        do begin
            issue(1'b0, 1'b0, '0, '0, '0);
        end while (wen_last);
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog: the cache hung, requests stopped completing in time");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

endmodule

// File: test/dcache_mem_model.sv
module dcache_mem_model #(
    parameter logic [31:0] SEED = 32'hca42
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_ren_i,
    input  dcache_bus_pkg::addr_t mem_araddr_i,
    output logic                  mem_rvalid_o,
    output dcache_bus_pkg::line_t mem_rdata_o,
    input  logic                  mem_wen_i,
    input  dcache_bus_pkg::addr_t mem_awaddr_i,
    input  dcache_bus_pkg::line_t mem_wdata_i,
    output logic                  mem_bvalid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 tags x 4 sets, slot is {addr[31:30], addr[6:5]}
    dcache_bus_pkg::line_t store [16];
    logic [31:0]           rng;
    int                    rd_cnt;
    int                    wr_cnt;
    logic                  rd_req;
    logic                  wr_req;
    dcache_bus_pkg::addr_t ar_seen;
    dcache_bus_pkg::addr_t ar_hold;
    dcache_bus_pkg::addr_t aw_seen;
    dcache_bus_pkg::addr_t aw_hold;
    dcache_bus_pkg::line_t wd_seen;
    dcache_bus_pkg::line_t wd_hold;

    function automatic logic [3:0] line_slot(input dcache_bus_pkg::addr_t a);
        return {a[31:30], a[6:5]};
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        dcache_bus_pkg::addr_t a;
        rng          = SEED;
        rd_cnt       = 0;
        wr_cnt       = 0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        mem_bvalid_o = 1'b0;
        // initial contents, every bit of the word address matters
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 8; w++) begin
                a = {s[3:2], 18'b0, 5'b0, s[1:0], w[2:0], 2'b00};
                store[s][32*w +: 32] = a * 32'h9e37_79b1 + 32'h2545_f491;
            end
        end
        forever begin
            // sample mid-cycle, respond 2 ns after the edge
            @(negedge clk);
            rd_req  = mem_ren_i && !mem_rvalid_o;
            wr_req  = mem_wen_i && !mem_bvalid_o;
            ar_seen = mem_araddr_i;
            aw_seen = mem_awaddr_i;
            wd_seen = mem_wdata_i;
            @(posedge clk);
            #2;
            mem_rvalid_o = 1'b0;
            mem_bvalid_o = 1'b0;
            if (rst) begin
                rd_cnt = 0;
                wr_cnt = 0;
            end else begin
                if (rd_cnt > 0) begin
                    rd_cnt--;
                    if (rd_cnt == 0) begin
                        mem_rvalid_o = 1'b1;
                        mem_rdata_o  = store[line_slot(ar_hold)];
                    end
                end else if (rd_req) begin
                    rng     = lcg_step(rng);
                    rd_cnt  = 2 + rng[31:16] % 8;
                    ar_hold = ar_seen;
                end
                if (wr_cnt > 0) begin
                    wr_cnt--;
                    if (wr_cnt == 0) begin
                        mem_bvalid_o                = 1'b1;
                        store[line_slot(aw_hold)] = wd_hold;
                    end
                end else if (wr_req) begin
                    rng     = lcg_step(rng);
                    wr_cnt  = 1 + rng[31:16] % 6;
                    aw_hold = aw_seen;
                    wd_hold = wd_seen;
                end
            end
        end
    end

endmodule

// File: verilog/dcache_top.sv
module dcache_top #(
    parameter int INDEX_W = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_rreq_i,
    input  logic                  cpu_wreq_i,
    input  dcache_bus_pkg::addr_t cpu_addr_i,
    input  dcache_bus_pkg::word_t cpu_wdata_i,
    input  dcache_bus_pkg::strb_t cpu_wsel_i,
    output logic                  cpu_rdata_valid_o,
    output dcache_bus_pkg::word_t cpu_rdata_o,
    output logic                  stall_o,
    input  logic                  mem_rvalid_i,
    input  dcache_bus_pkg::line_t mem_rdata_i,
    output logic                  mem_ren_o,
    output dcache_bus_pkg::addr_t mem_araddr_o,
    input  logic                  mem_bvalid_i,
    output logic                  mem_wen_o,
    output dcache_bus_pkg::addr_t mem_awaddr_o,
    output dcache_bus_pkg::line_t mem_wdata_o
);

    dcache_geom_pkg::way_vec_t valid;
    dcache_geom_pkg::way_vec_t dirty;
    dcache_geom_pkg::way_t     lru_way;
    dcache_geom_pkg::way_t     hit_way;
    logic                      hit;
    logic                      refill;
    logic                      write;
    logic                      victim_push;
    dcache_bus_pkg::addr_t     victim_addr;
    dcache_bus_pkg::line_t     victim_line;
    logic                      victim_busy;

    way_rd_if #(.INDEX_W(INDEX_W)) rd_bus ();
    way_wr_if #(.INDEX_W(INDEX_W)) wr_bus ();

    dcache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .cpu_rreq_i        (cpu_rreq_i),
        .cpu_wreq_i        (cpu_wreq_i),
        .cpu_addr_i        (cpu_addr_i),
        .cpu_wdata_i       (cpu_wdata_i),
        .cpu_wsel_i        (cpu_wsel_i),
        .cpu_rdata_valid_o (cpu_rdata_valid_o),
        .cpu_rdata_o       (cpu_rdata_o),
        .stall_o           (stall_o),
        .mem_rvalid_i      (mem_rvalid_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_ren_o         (mem_ren_o),
        .mem_araddr_o      (mem_araddr_o),
        .rd                (rd_bus),
        .wr                (wr_bus),
        .valid_i           (valid),
        .dirty_i           (dirty),
        .lru_way_i         (lru_way),
        .hit_o             (hit),
        .hit_way_o         (hit_way),
        .refill_o          (refill),
        .write_o           (write),
        .victim_push_o     (victim_push),
        .victim_addr_o     (victim_addr),
        .victim_line_o     (victim_line),
        .victim_busy_i     (victim_busy)
    );

    dcache_way_store #(
        .INDEX_W (INDEX_W)
    ) u_way_store (
        .clk (clk),
        .rd  (rd_bus),
        .wr  (wr_bus)
    );

    // write index is always the stage-2 set
    dcache_set_state #(
        .INDEX_W (INDEX_W)
    ) u_set_state (
        .clk       (clk),
        .rst       (rst),
        .index_i   (wr_bus.wr_index),
        .hit_i     (hit),
        .hit_way_i (hit_way),
        .refill_i  (refill),
        .write_i   (write),
        .valid_o   (valid),
        .dirty_o   (dirty),
        .lru_way_o (lru_way)
    );

    dcache_victim_buf u_victim_buf (
        .clk          (clk),
        .rst          (rst),
        .push_i       (victim_push),
        .addr_i       (victim_addr),
        .line_i       (victim_line),
        .busy_o       (victim_busy),
        .mem_bvalid_i (mem_bvalid_i),
        .mem_wen_o    (mem_wen_o),
        .mem_awaddr_o (mem_awaddr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

// File: verilog/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int INDEX_W = 7
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_rreq_i,
    input  logic                      cpu_wreq_i,
    input  dcache_bus_pkg::addr_t     cpu_addr_i,
    input  dcache_bus_pkg::word_t     cpu_wdata_i,
    input  dcache_bus_pkg::strb_t     cpu_wsel_i,
    output logic                      cpu_rdata_valid_o,
    output dcache_bus_pkg::word_t     cpu_rdata_o,
    output logic                      stall_o,
    input  logic                      mem_rvalid_i,
    input  dcache_bus_pkg::line_t     mem_rdata_i,
    output logic                      mem_ren_o,
    output dcache_bus_pkg::addr_t     mem_araddr_o,
    way_rd_if.ctrl                    rd,
    way_wr_if.ctrl                    wr,
    input  dcache_geom_pkg::way_vec_t valid_i,
    input  dcache_geom_pkg::way_vec_t dirty_i,
    input  dcache_geom_pkg::way_t     lru_way_i,
    output logic                      hit_o,
    output dcache_geom_pkg::way_t     hit_way_o,
    output logic                      refill_o,
    output logic                      write_o,
    output logic                      victim_push_o,
    output dcache_bus_pkg::addr_t     victim_addr_o,
    output dcache_bus_pkg::line_t     victim_line_o,
    input  logic                      victim_busy_i
);

    localparam int ADDR_W = $bits(dcache_bus_pkg::addr_t);
    localparam int WORD_W = $bits(dcache_bus_pkg::word_t);
    localparam int OFF_W  = dcache_geom_pkg::OFFSET_W;
    localparam int TAG_W  = ADDR_W - INDEX_W - OFF_W;

    logic                                     s2_rreq;
    logic                                     s2_wreq;
    dcache_bus_pkg::addr_t                    s2_addr;
    dcache_bus_pkg::word_t                    s2_wdata;
    dcache_bus_pkg::strb_t                    s2_wsel;
    logic [INDEX_W-1:0]                       s2_index;
    logic [TAG_W-1:0]                         s2_tag;
    logic [dcache_geom_pkg::LINE_OFF_W-1:0]   s2_word;
    logic                                     s2_req;
    dcache_geom_pkg::way_vec_t                hit_vec;
    logic                                     hit;
    logic                                     miss;
    dcache_geom_pkg::way_t                    hit_way;
    dcache_geom_pkg::way_t                    fill_way;
    dcache_bus_pkg::line_t                    base_line;
    dcache_bus_pkg::line_t                    merged_line;
    dcache_bus_pkg::word_t                    base_word;
    dcache_bus_pkg::word_t                    wmask;

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 request register, held during a stall
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_rreq <= 1'b0;
            s2_wreq <= 1'b0;
        end else if (!stall_o) begin
            s2_rreq <= cpu_rreq_i;
            s2_wreq <= cpu_wreq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            s2_addr  <= cpu_addr_i;
            s2_wdata <= cpu_wdata_i;
            s2_wsel  <= cpu_wsel_i;
        end
    end

    assign s2_index = s2_addr[OFF_W +: INDEX_W];
    assign s2_tag   = s2_addr[OFF_W + INDEX_W +: TAG_W];
    assign s2_word  = s2_addr[dcache_geom_pkg::WORD_OFF_W +: dcache_geom_pkg::LINE_OFF_W];
    assign s2_req   = s2_rreq | s2_wreq;

    // stage 1 array read, frozen on the stalled set
    assign rd.rd_en    = ~stall_o;
    assign rd.rd_index = stall_o ? s2_index : cpu_addr_i[OFF_W +: INDEX_W];

    ////////////////////////////////////////////////////////////////////////////
    // hit check, write merge and read data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_i[w] && (rd.rd_tag[w] == s2_tag);
        end
    end

    assign hit      = s2_req && (|hit_vec);
    assign miss     = s2_req && !(|hit_vec);
    assign hit_way  = hit_vec[1];
    assign fill_way = lru_way_i;

    // refill data replaces the array line in the pulse cycle
    assign base_line = miss ? mem_rdata_i : rd.rd_line[hit_way];
    assign base_word = base_line[s2_word*WORD_W +: WORD_W];

    always_comb begin
        for (int b = 0; b < $bits(dcache_bus_pkg::strb_t); b++) begin
            wmask[8*b +: 8] = {8{s2_wsel[b]}};
        end
    end

    always_comb begin
        merged_line = base_line;
        if (s2_wreq) begin
            merged_line[s2_word*WORD_W +: WORD_W] = (s2_wdata & wmask) | (base_word & ~wmask);
        end
    end

    assign cpu_rdata_o       = base_word;
    assign cpu_rdata_valid_o = s2_rreq && (hit || refill_o);

    ////////////////////////////////////////////////////////////////////////////
    // array writes, miss path and victim hand-off
    ////////////////////////////////////////////////////////////////////////////

    assign refill_o = miss && mem_rvalid_i;

    always_comb begin
        wr.wr_way_en = '0;
        if (refill_o) begin
            wr.wr_way_en[fill_way] = 1'b1;
        end else if (hit && s2_wreq) begin
            wr.wr_way_en[hit_way] = 1'b1;
        end
    end

    assign wr.wr_index = s2_index;
    assign wr.wr_tag   = s2_tag;
    assign wr.wr_line  = merged_line;

    assign hit_o     = hit;
    assign hit_way_o = hit_way;
    assign write_o   = s2_wreq;

    // memory read waits for an empty victim buffer
    assign stall_o      = miss && !mem_rvalid_i;
    assign mem_ren_o    = stall_o && !victim_busy_i;
    assign mem_araddr_o = {s2_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    // replaced line still sits on the held array read
    assign victim_push_o = refill_o && valid_i[fill_way] && dirty_i[fill_way];
    assign victim_addr_o = {rd.rd_tag[fill_way], s2_index, {OFF_W{1'b0}}};
    assign victim_line_o = rd.rd_line[fill_way];

    a_one_way_hit: assert property (
        @(posedge clk) disable iff (rst) s2_req |-> $onehot0(hit_vec)
    ) else $error("tag found in both ways of a set");

    // no write-back can start under an outstanding refill read
    a_ren_no_victim: assert property (
        @(posedge clk) disable iff (rst) mem_ren_o |=> !victim_busy_i
    ) else $error("victim buffer filled while a refill read was pending");

    a_push_when_free: assert property (
        @(posedge clk) disable iff (rst) victim_push_o |-> !victim_busy_i
    ) else $error("victim pushed into a full buffer");

endmodule

// File: verilog/dcache_victim_buf.sv
module dcache_victim_buf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_i,
    input  dcache_bus_pkg::addr_t addr_i,
    input  dcache_bus_pkg::line_t line_i,
    output logic                  busy_o,
    input  logic                  mem_bvalid_i,
    output logic                  mem_wen_o,
    output dcache_bus_pkg::addr_t mem_awaddr_o,
    output dcache_bus_pkg::line_t mem_wdata_o
);

    logic                  busy_q;
    dcache_bus_pkg::addr_t addr_q;
    dcache_bus_pkg::line_t line_q;

    // occupancy, filled at the refill edge, freed by the write response
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (push_i) begin
            busy_q <= 1'b1;
        end else if (mem_bvalid_i) begin
            busy_q <= 1'b0;
        end
    end

    // dirty line and its line address
    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_q <= addr_i;
            line_q <= line_i;
        end
    end

    assign busy_o       = busy_q;
    assign mem_wen_o    = busy_q;
    assign mem_awaddr_o = addr_q;
    assign mem_wdata_o  = line_q;

    // a write response belongs to the line held here
    a_bvalid_when_busy: assert property (
        @(posedge clk) disable iff (rst) mem_bvalid_i |-> busy_q
    ) else $error("write response with no victim line pending");

endmodule

// File: verilog/dcache_set_state.sv
module dcache_set_state #(
    parameter int INDEX_W = 7
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [INDEX_W-1:0]        index_i,
    input  logic                      hit_i,
    input  dcache_geom_pkg::way_t     hit_way_i,
    input  logic                      refill_i,
    input  logic                      write_i,
    output dcache_geom_pkg::way_vec_t valid_o,
    output dcache_geom_pkg::way_vec_t dirty_o,
    output dcache_geom_pkg::way_t     lru_way_o
);

    localparam int SETS = 2**INDEX_W;

    dcache_geom_pkg::way_vec_t [SETS-1:0] valid_q;
    dcache_geom_pkg::way_vec_t [SETS-1:0] dirty_q;
    // lru entry names the way to replace next
    dcache_geom_pkg::way_t [SETS-1:0]     lru_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (refill_i) begin
            // refill always lands in the lru way
            valid_q[index_i][lru_q[index_i]] <= 1'b1;
            dirty_q[index_i][lru_q[index_i]] <= write_i;
            lru_q[index_i]                   <= ~lru_q[index_i];
        end else if (hit_i) begin
            lru_q[index_i] <= ~hit_way_i;
            if (write_i) begin
                dirty_q[index_i][hit_way_i] <= 1'b1;
            end
        end
    end

    // combinational lookup for the stage-2 set
    assign valid_o   = valid_q[index_i];
    assign dirty_o   = dirty_q[index_i];
    assign lru_way_o = lru_q[index_i];

endmodule

// File: verilog/dcache_way_store.sv
module dcache_way_store #(
    parameter int INDEX_W = 7
) (
    input logic     clk,
    way_rd_if.store rd,
    way_wr_if.store wr
);

    localparam int TAG_W =
        $bits(dcache_bus_pkg::addr_t) - INDEX_W - dcache_geom_pkg::OFFSET_W;

    typedef logic [TAG_W-1:0] tag_t;

    // one tag array and one line array per way, all sharing the write index
    for (genvar w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin : g_way

        sdp_ram #(
            .DEPTH_W (INDEX_W),
            .entry_t (tag_t)
        ) u_tag_ram (
            .clk     (clk),
            .we_i    (wr.wr_way_en[w]),
            .waddr_i (wr.wr_index),
            .wdata_i (wr.wr_tag),
            .re_i    (rd.rd_en),
            .raddr_i (rd.rd_index),
            .rdata_o (rd.rd_tag[w])
        );

        sdp_ram #(
            .DEPTH_W (INDEX_W),
            .entry_t (dcache_bus_pkg::line_t)
        ) u_line_ram (
            .clk     (clk),
            .we_i    (wr.wr_way_en[w]),
            .waddr_i (wr.wr_index),
            .wdata_i (wr.wr_line),
            .re_i    (rd.rd_en),
            .raddr_i (rd.rd_index),
            .rdata_o (rd.rd_line[w])
        );

    end

endmodule

// File: verilog/sdp_ram.sv
module sdp_ram #(
    parameter int  DEPTH_W = 7,
    parameter type entry_t = logic [31:0]
) (
    input  logic               clk,
    input  logic               we_i,
    input  logic [DEPTH_W-1:0] waddr_i,
    input  entry_t             wdata_i,
    input  logic               re_i,
    input  logic [DEPTH_W-1:0] raddr_i,
    output entry_t             rdata_o
);

    entry_t mem [2**DEPTH_W];
    entry_t rd_q;
    entry_t byp_q;
    logic   byp_sel_q;

    // write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, output holds while re_i is low
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_q      <= mem[raddr_i];
            // same index written this cycle, array still has the old entry
            byp_sel_q <= we_i && (waddr_i == raddr_i);
            byp_q     <= wdata_i;
        end
    end

    assign rdata_o = byp_sel_q ? byp_q : rd_q;

endmodule

// File: verilog/dcache_array_if.sv
// read port of both ways
interface way_rd_if #(
    parameter int INDEX_W = 7
);
    localparam int TAG_W =
        $bits(dcache_bus_pkg::addr_t) - INDEX_W - dcache_geom_pkg::OFFSET_W;

    logic                                                  rd_en;
    logic [INDEX_W-1:0]                                    rd_index;
    logic [dcache_geom_pkg::NUM_WAYS-1:0][TAG_W-1:0]       rd_tag;
    dcache_bus_pkg::line_t [dcache_geom_pkg::NUM_WAYS-1:0] rd_line;

    modport ctrl (output rd_en, output rd_index, input rd_tag, input rd_line);
    modport store (input rd_en, input rd_index, output rd_tag, output rd_line);
endinterface

// write port, whole line plus tag into the enabled way
interface way_wr_if #(
    parameter int INDEX_W = 7
);
    localparam int TAG_W =
        $bits(dcache_bus_pkg::addr_t) - INDEX_W - dcache_geom_pkg::OFFSET_W;

    dcache_geom_pkg::way_vec_t wr_way_en;
    logic [INDEX_W-1:0]        wr_index;
    logic [TAG_W-1:0]          wr_tag;
    dcache_bus_pkg::line_t     wr_line;

    modport ctrl (output wr_way_en, output wr_index, output wr_tag, output wr_line);
    modport store (input wr_way_en, input wr_index, input wr_tag, input wr_line);
endinterface

// File: verilog/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // address split, low to high: byte in word, word in line, set index, tag
    localparam int WORD_OFF_W = 2;
    localparam int LINE_OFF_W = 3;
    localparam int OFFSET_W   = WORD_OFF_W + LINE_OFF_W;

    // associativity
    localparam int NUM_WAYS = 2;

    // way number, also the lru entry of a set
    typedef logic [0:0] way_t;

    // one bit per way, for valid, dirty and write enables
    typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage

// File: verilog/dcache_bus_pkg.sv
package dcache_bus_pkg;

    // cpu and memory bus widths
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;

    // byte address
    typedef logic [31:0] addr_t;

    // data word on the cpu side
    typedef logic [WORD_W-1:0] word_t;

    // one select per byte of a word
    typedef logic [WORD_W/8-1:0] strb_t;

    // full cache line, word 0 in the low bits
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

endpackage
